/* sources.f */
mul_arith_pkg.sv
mul_axil_pkg.sv
mul_req_if.sv
mul_res_if.sv
mul_axil_regs.sv
mul_req_fifo.sv
shift_add_mul.sv
mul_unit_top.sv
tb_mul_unit.sv

/* tb_mul_unit.sv */
`default_nettype none

module tb_mul_unit import mul_arith_pkg::*, mul_axil_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned fifo_depth = 4;
    localparam int unsigned wait_limit = 50;   // cycles for one bus handshake
    localparam int unsigned poll_limit = 200;  // status reads while waiting for a result

    logic       clk;
    logic       rst;
    logic       awvalid;
    logic       awready;
    axil_addr_t awaddr;
    logic       wvalid;
    logic       wready;
    axil_data_t wdata;
    logic       bvalid;
    logic       bready;
    axil_resp_t bresp;
    logic       arvalid;
    logic       arready;
    axil_addr_t araddr;
    logic       rvalid;
    logic       rready;
    axil_data_t rdata;
    axil_resp_t rresp;

    logic [15:0] lfsr_state;
    mul_tag_t    next_tag_exp;  // tags start at 0 and count accepted starts only
    product_t    exp_prod_q[$];
    mul_tag_t    exp_tag_q[$];
    string       exp_name_q[$];
    product_t    got_prod_q[$];
    mul_tag_t    got_tag_q[$];

    mul_unit_top #(
        .fifo_depth (fifo_depth)
    ) mul_unit_top_i (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped on the first error");
    endtask

    task automatic check_product(input string name, input product_t expected, input product_t actual);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_tag(input string name, input mul_tag_t expected, input mul_tag_t actual);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_resp(input string name, input axil_resp_t expected, input axil_resp_t actual);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    // 16-bit Galois LFSR, polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_operand(output operand_t v);
        for (int i = 0; i < 64; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    // low 64 bits of the full signed product
    function automatic product_t ref_mul(input operand_t a, input operand_t b);
        logic signed [127:0] full;
        full = $signed(a) * $signed(b);
        return full[63:0];
    endfunction

    // every bus task starts and ends on a falling edge
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data, output axil_resp_t resp);
        int unsigned n;
        n = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) fail_run("the write address and data channels never became ready");
        end
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = 1'b1;
        @(negedge clk);  // both channels taken on the rising edge in between
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) fail_run("no write response arrived");
        end
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data, output axil_resp_t resp);
        int unsigned n;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) fail_run("the read address channel never became ready");
        end
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) fail_run("no read data arrived");
        end
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_okay(input axil_addr_t addr, input axil_data_t data, input string name);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        check_resp(name, resp_okay, resp);
    endtask

    task automatic read_status(output axil_data_t st);
        axil_resp_t resp;
        axil_read(reg_status, st, resp);
        check_resp("status read", resp_okay, resp);
    endtask

    // an accepted start is recorded as an expected result with the next tag
    task automatic issue(input operand_t a, input operand_t b, input axil_resp_t exp_resp,
                         input string name);
        axil_resp_t resp;
        write_okay(reg_a_lo, a[31:0], {name, " a_lo"});
        write_okay(reg_a_hi, a[63:32], {name, " a_hi"});
        write_okay(reg_b_lo, b[31:0], {name, " b_lo"});
        write_okay(reg_b_hi, b[63:32], {name, " b_hi"});
        axil_write(reg_ctrl, 32'h1, resp);
        check_resp({name, " start"}, exp_resp, resp);
        if (exp_resp == resp_okay) begin
            exp_prod_q.push_back(ref_mul(a, b));
            exp_tag_q.push_back(next_tag_exp);
            exp_name_q.push_back(name);
            next_tag_exp++;
        end
    endtask

    task automatic collect_result();
        axil_data_t st;
        axil_data_t lo;
        axil_data_t hi;
        axil_resp_t resp;
        int unsigned n;
        n = 0;
        read_status(st);
        while (!st[0]) begin
            n++;
            if (n > poll_limit) fail_run("the result slot never filled");
            read_status(st);
        end
        axil_read(reg_res_lo, lo, resp);
        check_resp("res_lo read", resp_okay, resp);
        axil_read(reg_res_hi, hi, resp);  // this read empties the slot
        check_resp("res_hi read", resp_okay, resp);
        got_prod_q.push_back({hi, lo});
        got_tag_q.push_back(st[15:8]);
    endtask

    task automatic wait_compared();
        int unsigned n;
        n = 0;
        while (got_prod_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) fail_run("collected results were never compared");
        end
    endtask

    task automatic run_one(input operand_t a, input operand_t b, input string name);
        issue(a, b, resp_okay, name);
        collect_result();
        wait_compared();
    endtask

    always @(negedge clk) begin : compare_results
        product_t got_p;
        mul_tag_t got_t;
        if (got_prod_q.size() != 0) begin
            got_p = got_prod_q.pop_front();
            got_t = got_tag_q.pop_front();
            if (exp_prod_q.size() == 0) begin
                fail_run("a result came back that no request expected");
            end else begin
                check_product({exp_name_q[0], " product"}, exp_prod_q[0], got_p);
                check_tag({exp_name_q[0], " tag"}, exp_tag_q[0], got_t);
                void'(exp_prod_q.pop_front());
                void'(exp_tag_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end
    end

    initial begin : stimulus
        operand_t    a;
        operand_t    b;
        axil_data_t  st;
        axil_resp_t  resp;
        int unsigned issued;
        logic        full;
        rst          = 1'b1;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        lfsr_state   = 16'd42650;
        next_tag_exp = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        rand_operand(a);
        rand_operand(b);
        run_one(a, b, "single");

        rand_operand(a);
        run_one(a, 64'hFFFF_FFFF_FFFF_FFFD, "negative multiplier");
        run_one(64'd7, 64'hFFFF_FFFF_FFFF_FFFB, "small negative multiplier");
        rand_operand(b);
        run_one(64'd0, b, "zero multiplicand");
        run_one(a, 64'd0, "zero multiplier");
        run_one('1, '1, "all ones squared");
        run_one(64'h8000_0000_0000_0000, 64'd1, "most negative times one");
        run_one(64'h8000_0000_0000_0000, '1, "most negative times minus one");
        run_one(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, "most negative squared");
        rand_operand(a);
        rand_operand(b);
        run_one(a, b | 64'h8000_0000_0000_0000, "random negative multiplier");

        for (int i = 0; i < fifo_depth + 1; i++) begin
            rand_operand(a);
            rand_operand(b);
            issue(a, b, resp_okay, $sformatf("queued %0d", i));
        end
        for (int i = 0; i < fifo_depth + 1; i++) collect_result();
        wait_compared();

        // slot and queue both full, so the stalled engine cannot free an entry
        full   = 1'b0;
        issued = 0;
        while (!full) begin
            if (issued > 3 * fifo_depth) begin
                fail_run("the queue never reported full");
            end else begin
                rand_operand(a);
                rand_operand(b);
                issue(a, b, resp_okay, $sformatf("fill %0d", issued));
                issued++;
                read_status(st);
                full = st[0] && st[1];
            end
        end
        rand_operand(a);
        rand_operand(b);
        issue(a, b, resp_slverr, "start while full");
        for (int i = 0; i < issued; i++) collect_result();
        wait_compared();

        rand_operand(a);
        rand_operand(b);
        issue(a, b, resp_okay, "flushed 0");
        issue(b, a, resp_okay, "flushed 1");
        write_okay(reg_ctrl, 32'h2, "flush");
        exp_prod_q.delete();
        exp_tag_q.delete();
        exp_name_q.delete();
        rand_operand(a);
        rand_operand(b);
        run_one(a, b, "after flush");
        for (int i = 0; i < 40; i++) begin  // longer than one whole operation
            read_status(st);
            if (st[0]) fail_run("a flushed request still produced a result");
        end

        axil_write(5'h06, 32'h1, resp);
        check_resp("unmapped write", resp_slverr, resp);
        axil_read(5'h06, st, resp);
        check_resp("unmapped read", resp_slverr, resp);

        if (exp_prod_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run("some expected results never came back");
        end
    end

endmodule

`default_nettype wire

/* mul_unit_top.sv */
`default_nettype none

module mul_unit_top import mul_axil_pkg::*; #(
    parameter int unsigned fifo_depth = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    output logic       bvalid,
    input  logic       bready,
    output axil_resp_t bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    output axil_resp_t rresp
);

    logic flush;

    mul_req_if req_in ();   // front end into the queue
    mul_req_if req_out ();  // queue head into the engine
    mul_res_if res ();

    mul_axil_regs mul_axil_regs_i (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .req     (req_in),
        .res     (res),
        .flush   (flush)
    );

    mul_req_fifo #(
        .fifo_depth (fifo_depth)
    ) mul_req_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .wr    (req_in),
        .rd    (req_out)
    );

    shift_add_mul shift_add_mul_i (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .req   (req_out),
        .res   (res)
    );

endmodule

`default_nettype wire

/* shift_add_mul.sv */
`default_nettype none

module shift_add_mul import mul_arith_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    mul_req_if.sink   req,
    mul_res_if.source res
);

    localparam logic [6:0] last_step = 7'(mul_steps - 1);

    mul_state_t state;
    logic [6:0] step;
    operand_t   mcand;
    operand_t   mplier;
    logic       mplier_neg;
    product_t   acc;
    mul_tag_t   tag_q;
    product_t   partial;

    assign req.ready = (state == idle);

    assign res.valid     = (state == done);
    assign res.result_hi = acc[63:32];
    assign res.result_lo = acc[31:0];
    assign res.tag       = tag_q;

    assign partial = mplier[0] ? mcand : '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= idle;
            step  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (req.valid) begin
                        state <= busy;
                        step  <= '0;
                    end
                end
                busy: begin
                    if (step == last_step) begin
                        state <= done;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                done: if (res.ready) state <= idle;  // held here under back-pressure
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && req.valid) begin
            mcand      <= req.multiplicand;
            mplier     <= req.multiplier;
            mplier_neg <= req.multiplier[63];
            acc        <= '0;
            tag_q      <= req.tag;
        end else if (state == busy) begin
            // bit 63 of a negative multiplier carries weight -2^63, so the last
            // partial product is subtracted rather than added
            if (step == last_step && mplier_neg) begin
                acc <= acc - partial;
            end else begin
                acc <= acc + partial;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_step_in_range: assert property (
        @(posedge clk) disable iff (rst) (state == busy) |-> (step <= last_step)
    );

    // the front end may stall the result, which must not change while it waits
    a_result_held: assert property (
        @(posedge clk) disable iff (rst)
        (res.valid && !res.ready && !flush) |=>
            res.valid && $stable(res.result_hi) && $stable(res.result_lo) && $stable(res.tag)
    );

endmodule

`default_nettype wire

/* mul_req_fifo.sv */
`default_nettype none

module mul_req_fifo import mul_arith_pkg::*; #(
    parameter int unsigned fifo_depth = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    mul_req_if.sink   wr,
    mul_req_if.source rd
);

    localparam int unsigned ptr_w   = $clog2(fifo_depth);
    localparam int unsigned entry_w = 2 * $bits(operand_t) + $bits(mul_tag_t);

    logic [entry_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w:0]     count;
    logic               push;
    logic               pop;

    assign wr.ready = (count != fifo_depth);
    assign rd.valid = (count != '0);
    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;

    assign {rd.multiplicand, rd.multiplier, rd.tag} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= {wr.multiplicand, wr.multiplier, wr.tag};
    end

    // pointers wrap on their own because the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
        end
    end

    // a lone push must grow the queue by one without passing the depth
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        (push && !pop && !flush) |=> (count == $past(count) + 1'b1) && (count <= fifo_depth)
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        (pop && !push && !flush) |=> ($past(count) != '0) && (count == $past(count) - 1'b1)
    );

endmodule

`default_nettype wire

/* mul_axil_regs.sv */
`default_nettype none

module mul_axil_regs import mul_axil_pkg::*, mul_arith_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    output logic       bvalid,
    input  logic       bready,
    output axil_resp_t bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    output axil_resp_t rresp,
    mul_req_if.source  req,
    mul_res_if.sink    res,
    output logic       flush
);

    logic          aw_seen;
    logic          w_seen;
    axil_addr_t    wr_addr;
    axil_data_t    wr_data;
    logic          wr_exec;
    logic          ctrl_wr;
    operand_t      op_a;
    operand_t      op_b;
    mul_tag_t      next_tag;
    logic          slot_full;
    product_half_t slot_hi;
    product_half_t slot_lo;
    mul_tag_t      slot_tag;

    // each channel stays closed until its transaction has been answered
    assign awready = !aw_seen;
    assign wready  = !w_seen;
    assign arready = !rvalid;

    assign wr_exec = aw_seen && w_seen && !bvalid;  // address and data both held, response free
    assign ctrl_wr = wr_exec && (wr_addr == reg_ctrl);

    assign flush            = ctrl_wr && wr_data[ctrl_flush_bit];
    assign req.valid        = ctrl_wr && wr_data[ctrl_start_bit] && !wr_data[ctrl_flush_bit];
    assign req.multiplicand = op_a;
    assign req.multiplier   = op_b;
    assign req.tag          = next_tag;

    assign res.ready = !slot_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            bvalid  <= 1'b0;
        end else if (bvalid && bready) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awvalid && awready) aw_seen <= 1'b1;
            if (wvalid && wready) w_seen <= 1'b1;
            if (wr_exec) bvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) wr_addr <= awaddr;
        if (wvalid && wready) wr_data <= wdata;
        if (wr_exec) begin
            bresp <= resp_okay;
            case (wr_addr)
                reg_a_lo: op_a[31:0]  <= wr_data;
                reg_a_hi: op_a[63:32] <= wr_data;
                reg_b_lo: op_b[31:0]  <= wr_data;
                reg_b_hi: op_b[63:32] <= wr_data;
                reg_ctrl: if (req.valid && !req.ready) bresp <= resp_slverr;  // queue is full
                default:  bresp <= resp_slverr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag  <= '0;
            slot_full <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            if (req.valid && req.ready) next_tag <= next_tag + 1'b1;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                if (araddr == reg_res_hi) slot_full <= 1'b0;  // the high word pops the slot
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            // a result arriving only lands in an empty slot, so this never loses data
            if (res.valid && res.ready) slot_full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid && res.ready) begin
            slot_hi  <= res.result_hi;
            slot_lo  <= res.result_lo;
            slot_tag <= res.tag;
        end
        if (arvalid && arready) begin
            rdata <= '0;
            rresp <= resp_okay;
            case (araddr)
                reg_status: begin
                    rdata[0]    <= slot_full;
                    rdata[1]    <= !req.ready;
                    rdata[15:8] <= slot_tag;
                end
                reg_res_hi: rdata <= slot_hi;
                reg_res_lo: rdata <= slot_lo;
                default:    rresp <= resp_slverr;
            endcase
        end
    end

    // a response stays on the bus unchanged until the host takes it
    a_bresp_held: assert property (
        @(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid && $stable(bresp)
    );

    a_rdata_held: assert property (
        @(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

`default_nettype wire

/* mul_res_if.sv */
`default_nettype none

interface mul_res_if import mul_arith_pkg::*; ();

    logic          valid;
    logic          ready;
    product_half_t result_hi;
    product_half_t result_lo;
    mul_tag_t      tag;

    modport source (output valid, input ready, output result_hi, output result_lo, output tag);

    modport sink (input valid, output ready, input result_hi, input result_lo, input tag);

endinterface

`default_nettype wire

/* mul_req_if.sv */
`default_nettype none

interface mul_req_if import mul_arith_pkg::*; ();

    logic     valid;
    logic     ready;
    operand_t multiplicand;
    operand_t multiplier;
    mul_tag_t tag;

    // the side that offers a request
    modport source (
        output valid,
        input  ready,
        output multiplicand,
        output multiplier,
        output tag
    );

    modport sink (
        input  valid,
        output ready,
        input  multiplicand,
        input  multiplier,
        input  tag
    );

endinterface

`default_nettype wire

/* mul_axil_pkg.sv */
`default_nettype none

package mul_axil_pkg;

    typedef logic [4:0]  axil_addr_t;  // byte address inside the register window
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    localparam axil_addr_t reg_a_lo   = 5'h00;
    localparam axil_addr_t reg_a_hi   = 5'h04;
    localparam axil_addr_t reg_b_lo   = 5'h08;
    localparam axil_addr_t reg_b_hi   = 5'h0C;
    localparam axil_addr_t reg_ctrl   = 5'h10;
    localparam axil_addr_t reg_status = 5'h14;
    localparam axil_addr_t reg_res_lo = 5'h18;
    localparam axil_addr_t reg_res_hi = 5'h1C;

    // command bits of the ctrl register
    localparam int unsigned ctrl_start_bit = 0;
    localparam int unsigned ctrl_flush_bit = 1;

endpackage

`default_nettype wire

/* mul_arith_pkg.sv */
`default_nettype none

package mul_arith_pkg;

    typedef logic [63:0] operand_t;       // multiplicand or multiplier
    typedef logic [63:0] product_t;       // low 64 bits of the two's-complement product
    typedef logic [31:0] product_half_t;  // one result word as the host reads it
    typedef logic [7:0]  mul_tag_t;

    typedef enum logic [1:0] {
        idle,
        busy,
        done
    } mul_state_t;

    // one add-and-shift step per multiplier bit
    localparam int unsigned mul_steps = 64;

endpackage

`default_nettype wire
